// File: all.f
+incdir+testbench
hdl/tau_pkg.sv
hdl/bofs_if.sv
hdl/dram_if.sv
hdl/block_addr_gen.sv
hdl/prefix_accum.sv
hdl/tile_accum_unit.sv
hdl/block_looper.sv
hdl/mimori_top.sv
testbench/tb_clk_gen.sv
testbench/tb_top.sv

// File: hdl/block_addr_gen.sv
/*
 * block address generator
 * base plus each offset coordinate times its stride
 */
`timescale 1ns/10ps
`default_nettype none

module block_addr_gen (
	input  wire tau_pkg::gaddr_t i_base,
	input  wire tau_pkg::gaddr_t i_strides [tau_pkg::VDIM],
	input  wire tau_pkg::bofs_t  i_bofs,
	output tau_pkg::gaddr_t      o_addr
);
	import tau_pkg::*;

	always_comb begin
		gaddr_t acc;
		acc = i_base;
		for (int d = 0; d < VDIM; d++) begin
			acc = acc + gaddr_t'(i_bofs[d]) * i_strides[d]; // wraps at GBW bits
		end
		o_addr = acc;
	end

endmodule

`default_nettype wire

// File: hdl/block_looper.sv
/*
 * block looper for several tiles
 * walks the block grid and hands each offset to the lowest idle tile
 */
`timescale 1ns/10ps
`default_nettype none

module block_looper #(
	parameter int N_TAU = tau_pkg::N_TAU_DEFAULT
) (
	input  wire                 i_clk,
	input  wire                 i_rst_n,
	input  wire                 i_src_rdy,
	output logic                o_src_ack,
	input  wire tau_pkg::bofs_t i_bgrid_step,
	input  wire tau_pkg::bofs_t i_bgrid_end,
	bofs_if.looper              tau_bofs [N_TAU]
);
	import tau_pkg::*;

	wire  [N_TAU-1:0] ack_vec;
	wire  [N_TAU-1:0] done_vec;
	logic [N_TAU-1:0] busy;
	logic [N_TAU-1:0] busy_nxt;
	logic [N_TAU-1:0] rdy_q;    // at most one tile offered at a time
	logic [N_TAU-1:0] idle;
	logic [N_TAU-1:0] pick;
	logic             running;
	logic             all_issued;
	logic             all_issued_nxt;
	logic             start;
	logic             ack_hit;
	logic             fin;
	logic             last_blk;
	bofs_t            cur_bofs;
	bofs_t            nxt_bofs;

	genvar i;
	generate for (i = 0; i < N_TAU; i++) begin: g_port
		assign tau_bofs[i].rdy  = rdy_q[i];
		assign tau_bofs[i].bofs = cur_bofs; // only the offered tile looks
		assign ack_vec[i]       = tau_bofs[i].ack;
		assign done_vec[i]      = tau_bofs[i].done;
	end endgenerate

	//====================
	// grid walk
	//====================
	always_comb begin
		logic           carry;
		logic [WBW:0]   sum;
		carry = 1'b1;
		nxt_bofs = cur_bofs;
		for (int d = 0; d < VDIM; d++) begin
			sum = {1'b0, cur_bofs[d]} + {1'b0, i_bgrid_step[d]};
			if (carry) begin
				if (sum >= {1'b0, i_bgrid_end[d]}) begin
					nxt_bofs[d] = '0; // wrap, carry into next dim
				end else begin
					nxt_bofs[d] = sum[WBW-1:0];
					carry = 1'b0;
				end
			end
		end
		last_blk = carry; // every dim wrapped
	end

	//====================
	// dispatch control
	//====================
	assign start          = i_src_rdy && !running && !o_src_ack;
	assign ack_hit        = |(rdy_q & ack_vec);
	assign busy_nxt       = (busy | (rdy_q & ack_vec)) & ~done_vec;
	assign all_issued_nxt = all_issued || (ack_hit && last_blk);
	assign fin            = running && all_issued_nxt && (busy_nxt == '0);
	assign idle           = ~busy_nxt;
	assign pick           = idle & (~idle + 1'b1); // lowest idle tile

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			running    <= 1'b0;
			all_issued <= 1'b0;
			busy       <= '0;
			rdy_q      <= '0;
			o_src_ack  <= 1'b0;
			cur_bofs   <= '{default: '0};
		end else begin
			busy      <= busy_nxt;
			o_src_ack <= fin;
			if (start) begin
				running    <= 1'b1;
				all_issued <= 1'b0;
				cur_bofs   <= '{default: '0};
			end else begin
				if (fin) begin
					running    <= 1'b0;
					all_issued <= 1'b0;
				end else begin
					all_issued <= all_issued_nxt;
				end
				if (ack_hit) begin
					cur_bofs <= nxt_bofs;
				end
			end
			// hold the offer until it is taken
			if (rdy_q != '0 && !ack_hit) begin
				rdy_q <= rdy_q;
			end else if (start || (running && !all_issued_nxt)) begin
				rdy_q <= pick;
			end else begin
				rdy_q <= '0;
			end
		end
	end

	a_one_offer: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) $onehot0(rdy_q)
	);
	// no tile may still take a block or report one when the source is acked
	a_ack_idle: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_src_ack |-> (busy == '0) && (done_vec == '0) && (ack_vec == '0)
	);

endmodule

`default_nettype wire

// File: hdl/bofs_if.sv
/*
 * block offset channel from the looper to one tile
 * plus the tile's done pulse back
 */
`timescale 1ns/10ps
`default_nettype none

interface bofs_if;
	import tau_pkg::*;

	logic  rdy;
	logic  ack;
	bofs_t bofs;
	logic  done; // one cycle, write accepted

	modport looper (
		output rdy,
		output bofs,
		input  ack,
		input  done
	);

	modport tile (
		input  rdy,
		input  bofs,
		output ack,
		output done
	);

endinterface

`default_nettype wire

// File: hdl/dram_if.sv
/*
 * dram channels of one tile
 * read address, read data (dram to tile) and write
 */
`timescale 1ns/10ps
`default_nettype none

interface dram_if;
	import tau_pkg::*;

	// read address
	logic   ra_rdy;
	logic   ra_ack;
	gaddr_t ra_addr;
	// read data, sourced by dram
	logic   rd_rdy;
	logic   rd_ack;
	line_t  rd_data;
	// write
	logic   w_rdy;
	logic   w_ack;
	gaddr_t w_addr;
	line_t  w_data;

	modport tile (
		output ra_rdy, ra_addr, rd_ack, w_rdy, w_addr, w_data,
		input  ra_ack, rd_rdy, rd_data, w_ack
	);

	modport top (
		input  ra_rdy, ra_addr, rd_ack, w_rdy, w_addr, w_data,
		output ra_ack, rd_rdy, rd_data, w_ack
	);

endinterface

`default_nettype wire

// File: hdl/mimori_top.sv
/*
 * multi-core tile accumulation top
 * one block looper feeding N_TAU tiles, each with its own dram ports
 */
`timescale 1ns/10ps
`default_nettype none

module mimori_top #(
	parameter int N_TAU = tau_pkg::N_TAU_DEFAULT
) (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_src_rdy,
	output wire                   o_src_ack,
	input  wire tau_pkg::bofs_t   i_bgrid_step,                  // block shape
	input  wire tau_pkg::bofs_t   i_bgrid_end,                   // block shape * #block
	input  wire tau_pkg::gaddr_t  i_i0_linear,
	input  wire tau_pkg::gaddr_t  i_i0_strides [tau_pkg::VDIM],
	input  wire tau_pkg::gaddr_t  i_o_linear,
	input  wire tau_pkg::gaddr_t  i_o_strides  [tau_pkg::VDIM],
	output wire                   o_dramra_rdy [N_TAU],
	input  wire                   i_dramra_ack [N_TAU],
	output wire tau_pkg::gaddr_t  o_dramras    [N_TAU],
	input  wire                   i_dramrd_rdy [N_TAU],
	output wire                   o_dramrd_ack [N_TAU],
	input  wire tau_pkg::line_t   i_dramrds    [N_TAU],
	output wire                   o_dramw_rdy  [N_TAU],
	input  wire                   i_dramw_ack  [N_TAU],
	output wire tau_pkg::gaddr_t  o_dramwas    [N_TAU],
	output wire tau_pkg::line_t   o_dramwds    [N_TAU]
);

	//====================
	// looper
	//====================
	bofs_if u_bofs [N_TAU] ();

	block_looper #(
		.N_TAU(N_TAU)
	) u_pbl (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_src_rdy(i_src_rdy),
		.o_src_ack(o_src_ack),
		.i_bgrid_step(i_bgrid_step),
		.i_bgrid_end(i_bgrid_end),
		.tau_bofs(u_bofs)
	);

	//====================
	// tiles
	//====================
	genvar i;
	generate for (i = 0; i < N_TAU; i++) begin: g_tau
		dram_if u_dram ();

		tile_accum_unit u_tau (
			.i_clk(i_clk),
			.i_rst_n(i_rst_n),
			.blk(u_bofs[i]),
			.dram(u_dram),
			.i_i0_linear(i_i0_linear),
			.i_i0_strides(i_i0_strides),
			.i_o_linear(i_o_linear),
			.i_o_strides(i_o_strides)
		);

		// tile side to top-level dram ports
		assign o_dramra_rdy[i]  = u_dram.ra_rdy;
		assign o_dramras[i]     = u_dram.ra_addr;
		assign u_dram.ra_ack    = i_dramra_ack[i];
		assign u_dram.rd_rdy    = i_dramrd_rdy[i];
		assign u_dram.rd_data   = i_dramrds[i];
		assign o_dramrd_ack[i]  = u_dram.rd_ack;
		assign o_dramw_rdy[i]   = u_dram.w_rdy;
		assign o_dramwas[i]     = u_dram.w_addr;
		assign o_dramwds[i]     = u_dram.w_data;
		assign u_dram.w_ack     = i_dramw_ack[i];
	end endgenerate

endmodule

`default_nettype wire

// File: hdl/prefix_accum.sv
/*
 * running sum over the words of one cache line
 */
`timescale 1ns/10ps
`default_nettype none

module prefix_accum (
	input  wire tau_pkg::line_t i_line,
	output tau_pkg::line_t      o_line
);
	import tau_pkg::*;

	always_comb begin
		data_t acc;
		acc = '0;
		for (int k = 0; k < CSIZE; k++) begin
			acc = acc + i_line[k]; // modulo 2^DBW
			o_line[k] = acc;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tau_pkg.sv
/*
 * tile accumulation shared definitions
 * widths, array sizes and payload types used across the design
 */
`default_nettype none

package tau_pkg;

	//====================
	// widths and sizes
	//====================
	parameter int VDIM          = 2;  // grid dimensions
	parameter int CSIZE         = 4;  // words per cache line
	parameter int DBW           = 16; // data word
	parameter int GBW           = 32; // dram address
	parameter int WBW           = 16; // grid coordinate
	parameter int N_TAU_DEFAULT = 2;

	//====================
	// types
	//====================
	typedef logic [WBW-1:0] work_t;
	typedef work_t bofs_t [VDIM];     // one block offset, dim 0 innermost
	typedef logic [GBW-1:0] gaddr_t;
	typedef logic [DBW-1:0] data_t;
	typedef data_t line_t [CSIZE];    // one dram cache line

endpackage

`default_nettype wire

// File: hdl/tile_accum_unit.sv
/*
 * tile accumulation unit
 * reads one line, replaces it by its prefix sums, writes it back
 */
`timescale 1ns/10ps
`default_nettype none

module tile_accum_unit (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	bofs_if.tile                 blk,
	dram_if.tile                 dram,
	input  wire tau_pkg::gaddr_t i_i0_linear,
	input  wire tau_pkg::gaddr_t i_i0_strides [tau_pkg::VDIM],
	input  wire tau_pkg::gaddr_t i_o_linear,
	input  wire tau_pkg::gaddr_t i_o_strides  [tau_pkg::VDIM]
);
	import tau_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RADDR,
		S_RDATA,
		S_WRITE,
		S_DONE
	} state_t;

	state_t state;
	state_t state_nxt;
	bofs_t  bofs_q;  // offset of the block in flight
	line_t  line_q;
	line_t  sum_line;
	gaddr_t rd_addr;
	gaddr_t wr_addr;

	//====================
	// datapath
	//====================
	block_addr_gen u_rd_addr (
		.i_base(i_i0_linear),
		.i_strides(i_i0_strides),
		.i_bofs(bofs_q),
		.o_addr(rd_addr)
	);

	block_addr_gen u_wr_addr (
		.i_base(i_o_linear),
		.i_strides(i_o_strides),
		.i_bofs(bofs_q),
		.o_addr(wr_addr)
	);

	prefix_accum u_accum (
		.i_line(line_q),
		.o_line(sum_line)
	);

	assign blk.ack      = (state == S_IDLE) && blk.rdy;
	assign blk.done     = (state == S_DONE);
	assign dram.ra_rdy  = (state == S_RADDR);
	assign dram.ra_addr = rd_addr;
	assign dram.rd_ack  = (state == S_RDATA) && dram.rd_rdy; // take line as soon as it shows
	assign dram.w_rdy   = (state == S_WRITE);
	assign dram.w_addr  = wr_addr;
	assign dram.w_data  = sum_line;

	//====================
	// sequencer
	//====================
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:  if (blk.rdy)     state_nxt = S_RADDR;
			S_RADDR: if (dram.ra_ack) state_nxt = S_RDATA;
			S_RDATA: if (dram.rd_rdy) state_nxt = S_WRITE;
			S_WRITE: if (dram.w_ack)  state_nxt = S_DONE;
			S_DONE:  state_nxt = S_IDLE;
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge i_clk) begin
		if (blk.ack) begin
			bofs_q <= blk.bofs;
		end
		if (dram.rd_ack) begin
			line_q <= dram.rd_data;
		end
	end

	// address must not move while dram stalls the request
	a_ra_stable: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		dram.ra_rdy && !dram.ra_ack |=> $stable(dram.ra_addr)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
/*
 * testbench clock and reset generator
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1; // released off the edge
	end

endmodule

`default_nettype wire

// File: testbench/tb_checks.svh
/*
 * testbench compare tasks and error counters
 * plus the data rule of the dram model
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int val_errs  = 0; // wrong values
int misc_errs = 0; // timeouts, missing or extra transfers

task automatic check_addr(input string name, input gaddr_t exp, input gaddr_t act);
	if (exp !== act) begin
		val_errs++;
		$display("FAILED %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_data(input string name, input data_t exp, input data_t act);
	if (exp !== act) begin
		val_errs++;
		$display("FAILED %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (exp !== act) begin
		val_errs++;
		$display("FAILED %s expected %b actual %b", name, exp, act);
	end
endtask

task automatic report_error(input string what);
	misc_errs++;
	$display("error: %s", what);
endtask

// word k of the line returned for read address a
function automatic data_t rule_word(input gaddr_t a, input int k);
	return data_t'(a[15:0] + 3 * k);
endfunction

// sum of rule words 0..k in closed form
function automatic data_t rule_sum(input gaddr_t a, input int k);
	return data_t'((k + 1) * a[15:0] + (3 * k * (k + 1)) / 2);
endfunction

`endif

// File: testbench/tb_top.sv
/*
 * testbench for the multi-core tile accumulation top
 * per-tile dram model with optional random stalls, directed tests
 */
`timescale 1ns/10ps
`default_nettype none

module tb_top;
	import tau_pkg::*;

	localparam int N_TAU   = N_TAU_DEFAULT;
	localparam int TIMEOUT = 400; // cycles per wait

	logic   i_clk;
	logic   i_rst_n;
	logic   i_src_rdy;
	logic   o_src_ack;
	bofs_t  i_bgrid_step;
	bofs_t  i_bgrid_end;
	gaddr_t i_i0_linear;
	gaddr_t i_o_linear;
	gaddr_t i_i0_strides [VDIM];
	gaddr_t i_o_strides  [VDIM];
	logic   o_dramra_rdy [N_TAU];
	logic   i_dramra_ack [N_TAU];
	gaddr_t o_dramras    [N_TAU];
	logic   i_dramrd_rdy [N_TAU];
	logic   o_dramrd_ack [N_TAU];
	line_t  i_dramrds    [N_TAU];
	logic   o_dramw_rdy  [N_TAU];
	logic   i_dramw_ack  [N_TAU];
	gaddr_t o_dramwas    [N_TAU];
	line_t  o_dramwds    [N_TAU];

	int     seed = 18252;
	bit     rand_on;
	bit     timed_out;
	string  cur_test;
	int     ra_wait [N_TAU]; // -1 while no delay is drawn
	int     rd_wait [N_TAU];
	int     w_wait  [N_TAU];
	bit     rd_pend [N_TAU];
	gaddr_t rd_src  [N_TAU]; // last read address per tile
	int     rd_cnt  [N_TAU];
	gaddr_t wr_log  [$];
	gaddr_t wr_src  [$];     // read address behind each write

	`include "tb_checks.svh"

	tb_clk_gen u_clk (.o_clk(i_clk), .o_rst_n(i_rst_n));

	mimori_top #(.N_TAU(N_TAU)) dut_i (.*);

	function automatic int draw_delay();
		return rand_on ? int'($unsigned($random(seed)) % 4) : 0;
	endfunction

	// 1 once the drawn delay has run out
	function automatic bit delay_done(inout int w);
		if (w < 0) begin
			w = draw_delay();
		end
		if (w == 0) begin
			w = -1;
			return 1'b1;
		end
		w--;
		return 1'b0;
	endfunction

	function automatic gaddr_t blk_addr(input gaddr_t base, input gaddr_t s [VDIM],
			input int o0, input int o1);
		return base + gaddr_t'(o0) * s[0] + gaddr_t'(o1) * s[1];
	endfunction

	//====================
	// dram model
	//====================
	initial begin
		bit     ra_x    [N_TAU];
		bit     rd_x    [N_TAU];
		bit     w_x     [N_TAU];
		bit     ra_hold [N_TAU];
		gaddr_t ra_s    [N_TAU];
		gaddr_t wa_s    [N_TAU];
		line_t  wd_s    [N_TAU];
		for (int t = 0; t < N_TAU; t++) begin
			i_dramra_ack[t] = 1'b0;
			i_dramrd_rdy[t] = 1'b0;
			i_dramrds[t]    = '{default: '0};
			i_dramw_ack[t]  = 1'b0;
			ra_wait[t]      = -1;
			rd_wait[t]      = -1;
			w_wait[t]       = -1;
			rd_pend[t]      = 1'b0;
			rd_cnt[t]       = 0;
			ra_hold[t]      = 1'b0;
		end
		forever begin
			@(negedge i_clk); // handshakes are stable mid cycle
			for (int t = 0; t < N_TAU; t++) begin
				ra_x[t] = o_dramra_rdy[t] && i_dramra_ack[t];
				rd_x[t] = i_dramrd_rdy[t] && o_dramrd_ack[t];
				w_x[t]  = o_dramw_rdy[t] && i_dramw_ack[t];
				if (ra_hold[t]) begin
					check_addr({cur_test, " ra hold"}, ra_s[t], o_dramras[t]);
				end
				ra_hold[t] = o_dramra_rdy[t] && !i_dramra_ack[t];
				ra_s[t]    = o_dramras[t];
				wa_s[t]    = o_dramwas[t];
				wd_s[t]    = o_dramwds[t];
			end
			@(posedge i_clk);
			#1;
			for (int t = 0; t < N_TAU; t++) begin
				if (ra_x[t]) begin
					i_dramra_ack[t] = 1'b0;
					rd_src[t]       = ra_s[t];
					rd_pend[t]      = 1'b1;
					rd_cnt[t]++;
				end else if (o_dramra_rdy[t] && !i_dramra_ack[t] && delay_done(ra_wait[t])) begin
					i_dramra_ack[t] = 1'b1;
				end
				if (rd_x[t]) begin
					i_dramrd_rdy[t] = 1'b0;
					rd_pend[t]      = 1'b0;
				end else if (rd_pend[t] && !i_dramrd_rdy[t] && delay_done(rd_wait[t])) begin
					i_dramrd_rdy[t] = 1'b1;
					for (int k = 0; k < CSIZE; k++) begin
						i_dramrds[t][k] = rule_word(rd_src[t], k);
					end
				end
				if (w_x[t]) begin
					i_dramw_ack[t] = 1'b0;
					wr_log.push_back(wa_s[t]);
					wr_src.push_back(rd_src[t]);
					for (int k = 0; k < CSIZE; k++) begin
						check_data(cur_test, rule_sum(rd_src[t], k), wd_s[t][k]);
					end
				end else if (o_dramw_rdy[t] && !i_dramw_ack[t] && delay_done(w_wait[t])) begin
					i_dramw_ack[t] = 1'b1;
				end
			end
		end
	end

	//====================
	// helpers
	//====================
	task automatic note_timeout(input string what);
		report_error({cur_test, " timed out waiting for ", what});
		timed_out = 1'b1;
	endtask

	task automatic check_quiet();
		check_flag({cur_test, " src_ack"}, 1'b0, o_src_ack);
		for (int t = 0; t < N_TAU; t++) begin
			check_flag({cur_test, " ra_rdy"}, 1'b0, o_dramra_rdy[t]);
			check_flag({cur_test, " rd_ack"}, 1'b0, o_dramrd_ack[t]);
			check_flag({cur_test, " w_rdy"}, 1'b0, o_dramw_rdy[t]);
		end
	endtask

	task automatic set_grid(input int step0, input int end0, input int step1, input int end1);
		@(posedge i_clk);
		#1;
		i_bgrid_step = '{work_t'(step0), work_t'(step1)};
		i_bgrid_end  = '{work_t'(end0), work_t'(end1)};
	endtask

	// raise one source request and wait for o_src_ack
	task automatic run_blocks(input int n_blocks);
		int n;
		int reads;
		int writes_at_ack;
		logic got;
		wr_log.delete();
		wr_src.delete();
		for (int t = 0; t < N_TAU; t++) begin
			rd_cnt[t] = 0;
		end
		@(posedge i_clk);
		#1;
		i_src_rdy = 1'b1;
		n = 0;
		do begin
			@(negedge i_clk);
			n++;
		end while (o_src_ack !== 1'b1 && n < TIMEOUT);
		got           = o_src_ack;
		writes_at_ack = wr_log.size();
		@(posedge i_clk);
		#1;
		i_src_rdy = 1'b0;
		if (got !== 1'b1) begin
			note_timeout("o_src_ack");
		end else begin
			if (writes_at_ack != n_blocks) begin
				report_error($sformatf("%s o_src_ack after %0d writes, %0d expected",
					cur_test, writes_at_ack, n_blocks));
			end
			@(negedge i_clk);
			check_flag({cur_test, " src_ack pulse"}, 1'b0, o_src_ack);
			repeat (6) @(negedge i_clk); // no restart or late traffic
			reads = 0;
			for (int t = 0; t < N_TAU; t++) begin
				reads += rd_cnt[t];
			end
			if (reads != n_blocks || wr_log.size() != n_blocks) begin
				report_error($sformatf("%s saw %0d reads and %0d writes for %0d blocks",
					cur_test, reads, wr_log.size(), n_blocks));
			end
		end
	endtask

	// every offset written exactly once from its own read address
	task automatic check_writes(input int n0, input int n1);
		gaddr_t wa;
		gaddr_t ra;
		int     hits;
		for (int o1 = 0; o1 < n1; o1++) begin
			for (int o0 = 0; o0 < n0; o0++) begin
				wa = blk_addr(i_o_linear, i_o_strides, o0 * i_bgrid_step[0],
					o1 * i_bgrid_step[1]);
				ra = blk_addr(i_i0_linear, i_i0_strides, o0 * i_bgrid_step[0],
					o1 * i_bgrid_step[1]);
				hits = 0;
				foreach (wr_log[j]) begin
					if (wr_log[j] == wa) begin
						hits++;
						check_addr({cur_test, " read of block"}, ra, wr_src[j]);
					end
				end
				if (hits != 1) begin
					report_error($sformatf("%s write to %h seen %0d times", cur_test, wa, hits));
				end
			end
		end
	endtask

	//====================
	// tests
	//====================
	task automatic reset_quiet();
		int n;
		cur_test = "reset";
		n = 0;
		do begin
			@(negedge i_clk);
			check_quiet();
			n++;
		end while (!i_rst_n && n < TIMEOUT);
		if (!i_rst_n) begin
			note_timeout("reset release");
		end
		repeat (3) begin
			@(negedge i_clk);
			check_quiet();
		end
	endtask

	task automatic single_block();
		cur_test = "single";
		set_grid(4, 4, 1, 1);
		run_blocks(1);
		check_writes(1, 1);
	endtask

	task automatic grid_of_six();
		cur_test = "grid";
		set_grid(4, 12, 1, 2); // 3 x 2 blocks
		run_blocks(6);
		check_writes(3, 2);
	endtask

	task automatic wrap_sums();
		cur_test    = "wrap";
		set_grid(4, 4, 1, 1);
		i_i0_linear = 32'h0000_FFF0; // words near the top of 16 bits
		run_blocks(1);
		check_writes(1, 1);
		@(posedge i_clk);
		#1;
		i_i0_linear = 32'h0000_1000;
	endtask

	task automatic backpressure();
		cur_test = "backpressure";
		rand_on  = 1'b1;
		set_grid(4, 12, 1, 2);
		run_blocks(6);
		check_writes(3, 2);
		for (int t = 0; t < N_TAU; t++) begin
			if (rd_cnt[t] == 0) begin
				report_error($sformatf("%s tile %0d never issued a read", cur_test, t));
			end
		end
		rand_on = 1'b0;
	endtask

	task automatic finish_run();
		$display("errors: %0d value, %0d other", val_errs, misc_errs);
		if (val_errs + misc_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	initial begin
		i_src_rdy    = 1'b0;
		rand_on      = 1'b0;
		timed_out    = 1'b0;
		cur_test     = "init";
		i_bgrid_step = '{16'd4, 16'd1};
		i_bgrid_end  = '{16'd4, 16'd1};
		i_i0_linear  = 32'h0000_1000;
		i_i0_strides = '{32'h0000_0010, 32'h0000_0400};
		i_o_linear   = 32'h0000_8000;
		i_o_strides  = '{32'h0000_0008, 32'h0000_0200};
		reset_quiet();
		if (!timed_out) begin
			single_block();
		end
		if (!timed_out) begin
			grid_of_six();
		end
		if (!timed_out) begin
			wrap_sums();
		end
		if (!timed_out) begin
			backpressure();
		end
		finish_run();
	end

endmodule

`default_nettype wire
